/* rtl/nvme_write_pkg.sv */
package nvme_write_pkg;

  // queue geometry, one slot per command identifier
  localparam int queue_depth = 16;
  localparam int slot_bits = 4;
  localparam int sq_entry_bytes = 64;
  localparam int cq_entry_bytes = 16;

  // write buffer window in the device address map
  localparam int buf_slot_bytes = 4096;
  localparam int unsigned write_buf_base = 516 * 1024 * 1024;

  // command fields
  localparam int opcode_write = 1;
  localparam int nsid_default = 1;
  localparam int lba_shift = 12;

  typedef logic [slot_bits-1:0] slot_t;
  typedef logic [47:0] host_addr_t;
  typedef logic [9:0] sq_addr_t;
  typedef logic [15:0] buf_addr_t;
  typedef logic [7:0] cq_addr_t;
  typedef logic [15:0] db_value_t;
  typedef logic [511:0] sq_entry_t;

  typedef struct packed {
    host_addr_t addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } host_aw_t;

  typedef struct packed {
    logic [127:0] data;
    logic [15:0]  strb;
    logic         last;
  } host_w_t;

  typedef struct packed {
    buf_addr_t  addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } buf_aw_t;

  // completion entry, status in the top bits
  typedef struct packed {
    logic [14:0] status;
    logic        phase;
    logic [15:0] cid;
    logic [15:0] sqid;
    logic [15:0] sq_head;
    logic [63:0] dw;
  } cq_entry_t;

  typedef enum logic [1:0] {
    idle,
    busy_ar,
    busy_r,
    busy_db
  } poll_state_t;

endpackage

/* rtl/valid_fork.sv */
`timescale 1ns/100ps

module valid_fork #(
  parameter int num_out = 2
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               in_valid,
  output logic               in_ready,
  output logic [num_out-1:0] out_valid,
  input  logic [num_out-1:0] out_ready
);

  // channels that already took the current beat
  logic [num_out-1:0] done;
  logic [num_out-1:0] accept;

  always_comb begin
    out_valid = {num_out{in_valid}} & ~done;
    accept = out_valid & out_ready;
    in_ready = in_valid & (&(done | accept));
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      done <= '0;
    end else if (in_valid && !in_ready) begin
      done <= done | accept;
    end else begin
      done <= '0;
    end
  end

  // upstream must hold valid until the whole set is through
  done_needs_valid: assert property (
    @(posedge clk) disable iff (!rstn) !in_valid |-> done == '0
  );

endmodule

/* rtl/sq_submit.sv */
`timescale 1ns/100ps

module sq_submit (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  nvme_write_pkg::host_aw_t              host_aw,
  input  logic                                  host_aw_valid,
  output logic                                  host_aw_ready,
  input  nvme_write_pkg::slot_t                 sq_head,
  input  logic [nvme_write_pkg::queue_depth-1:0] cid_busy,
  output nvme_write_pkg::slot_t                 sq_tail,
  output nvme_write_pkg::sq_addr_t              sq_aw_addr,
  output logic                                  sq_aw_valid,
  input  logic                                  sq_aw_ready,
  output nvme_write_pkg::sq_entry_t             sq_w_data,
  output logic                                  sq_w_valid,
  input  logic                                  sq_w_ready,
  output nvme_write_pkg::buf_aw_t               buf_aw,
  output logic                                  buf_aw_valid,
  input  logic                                  buf_aw_ready
);

  logic       q_full;
  logic       cid_blocked;
  logic       cmd_valid;
  logic [2:0] fork_valid;
  logic [2:0] fork_ready;

  // tail doubles as the command identifier
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      sq_tail <= '0;
    end else if (host_aw_valid && host_aw_ready) begin
      sq_tail <= nvme_write_pkg::slot_t'(sq_tail + 1'b1);
    end
  end

  always_comb begin
    // one slot stays empty so full and empty differ
    q_full = nvme_write_pkg::slot_t'(sq_tail + 1'b1) == sq_head;
    cid_blocked = cid_busy[sq_tail];
    cmd_valid = host_aw_valid & ~q_full & ~cid_blocked;
  end

  valid_fork #(
    .num_out(3)
  ) u_fork (
    .clk(clk),
    .rstn(rstn),
    .in_valid(cmd_valid),
    .in_ready(host_aw_ready),
    .out_valid(fork_valid),
    .out_ready(fork_ready)
  );

  always_comb begin
    sq_aw_valid = fork_valid[0];
    sq_w_valid = fork_valid[1];
    buf_aw_valid = fork_valid[2];
    fork_ready = {buf_aw_ready, sq_w_ready, sq_aw_ready};

    sq_aw_addr = nvme_write_pkg::sq_addr_t'(32'(sq_tail) * nvme_write_pkg::sq_entry_bytes);

    // write command, unused dwords stay zero
    sq_w_data = '0;
    sq_w_data[7:0] = 8'(nvme_write_pkg::opcode_write);
    sq_w_data[31:16] = 16'(sq_tail);
    sq_w_data[63:32] = 32'(nvme_write_pkg::nsid_default);
    // prp1 points at this slot of the write buffer
    sq_w_data[255:192] = 64'(nvme_write_pkg::write_buf_base)
                       + 64'(sq_tail) * 64'(nvme_write_pkg::buf_slot_bytes);
    // starting lba, one 4 KiB block per command
    sq_w_data[383:320] = 64'(host_aw.addr >> nvme_write_pkg::lba_shift);

    buf_aw.addr = nvme_write_pkg::buf_addr_t'(32'(sq_tail) * nvme_write_pkg::buf_slot_bytes);
    buf_aw.len = host_aw.len;
    buf_aw.size = host_aw.size;
    buf_aw.burst = host_aw.burst;
  end

  // a partly accepted command keeps its fields for the other channels
  aw_held_until_ready: assert property (
    @(posedge clk) disable iff (!rstn)
    host_aw_valid && !host_aw_ready |=> host_aw_valid && $stable(host_aw)
  );

endmodule

/* rtl/sq_doorbell.sv */
`timescale 1ns/100ps

module sq_doorbell (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      sq_b_valid,
  output logic                      sq_b_ready,
  input  logic                      buf_b_valid,
  output logic                      buf_b_ready,
  output nvme_write_pkg::db_value_t sq_db_value,
  output logic                      sq_db_valid,
  input  logic                      sq_db_ready
);

  // tail as last told to the device
  nvme_write_pkg::slot_t db_tail;
  logic                  ring;

  always_comb begin
    sq_db_valid = sq_b_valid & buf_b_valid;
    sq_db_value = nvme_write_pkg::db_value_t'(nvme_write_pkg::slot_t'(db_tail + 1'b1));
    ring = sq_db_valid & sq_db_ready;
    // both responses retire with the doorbell
    sq_b_ready = ring;
    buf_b_ready = ring;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      db_tail <= '0;
    end else if (ring) begin
      db_tail <= nvme_write_pkg::slot_t'(db_tail + 1'b1);
    end
  end

  // a doorbell on offer stays put until the device takes it
  db_held_until_ring: assert property (
    @(posedge clk) disable iff (!rstn)
    sq_db_valid && !sq_db_ready |=> sq_db_valid && $stable(sq_db_value)
  );

endmodule

/* rtl/cq_poller.sv */
`timescale 1ns/100ps

module cq_poller (
  input  logic                                   clk,
  input  logic                                   rstn,
  input  logic                                   sq_db_b_valid,
  output logic                                   sq_db_b_ready,
  output nvme_write_pkg::cq_addr_t               cq_ar_addr,
  output logic                                   cq_ar_valid,
  input  logic                                   cq_ar_ready,
  input  nvme_write_pkg::cq_entry_t              cq_r_data,
  input  logic                                   cq_r_valid,
  output logic                                   cq_r_ready,
  output nvme_write_pkg::db_value_t              cq_db_value,
  output logic                                   cq_db_valid,
  input  logic                                   cq_db_ready,
  input  logic                                   cq_db_b_valid,
  output logic                                   cq_db_b_ready,
  output logic                                   host_b_valid,
  input  logic                                   host_b_ready,
  input  logic                                   issue_valid,
  input  nvme_write_pkg::slot_t                  issue_cid,
  output nvme_write_pkg::slot_t                  sq_head,
  output logic [nvme_write_pkg::queue_depth-1:0] cid_busy
);

  nvme_write_pkg::poll_state_t          state;
  nvme_write_pkg::slot_t                cq_head;
  logic                                 old_phase;
  logic                                 fresh;
  logic                                 db_valid;
  logic                                 db_done;
  logic                                 cq_db_fire;
  logic [1:0]                           fork_valid;
  logic [1:0]                           fork_ready;
  // cq doorbells still waiting for their response
  logic [nvme_write_pkg::slot_bits:0]   db_open;

  always_comb begin
    sq_db_b_ready = state == nvme_write_pkg::idle;
    cq_ar_valid = state == nvme_write_pkg::busy_ar;
    cq_ar_addr = nvme_write_pkg::cq_addr_t'(32'(cq_head) * nvme_write_pkg::cq_entry_bytes);
    cq_r_ready = state == nvme_write_pkg::busy_r;
    // a tag equal to old_phase is left over from the last lap
    fresh = cq_r_valid & cq_r_ready & (cq_r_data.phase != old_phase);
    db_valid = state == nvme_write_pkg::busy_db;
    cq_db_valid = fork_valid[0];
    host_b_valid = fork_valid[1];
    fork_ready = {host_b_ready, cq_db_ready};
    cq_db_value = nvme_write_pkg::db_value_t'(cq_head);
    cq_db_fire = cq_db_valid & cq_db_ready;
    cq_db_b_ready = 1'b1;
  end

  // cq doorbell and host response leave together
  valid_fork #(
    .num_out(2)
  ) u_fork (
    .clk(clk),
    .rstn(rstn),
    .in_valid(db_valid),
    .in_ready(db_done),
    .out_valid(fork_valid),
    .out_ready(fork_ready)
  );

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= nvme_write_pkg::idle;
      cq_head <= '0;
      old_phase <= 1'b0;
      sq_head <= '0;
    end else begin
      unique case (state)
        nvme_write_pkg::idle: begin
          if (sq_db_b_valid) begin
            state <= nvme_write_pkg::busy_ar;
          end
        end
        nvme_write_pkg::busy_ar: begin
          if (cq_ar_ready) begin
            state <= nvme_write_pkg::busy_r;
          end
        end
        nvme_write_pkg::busy_r: begin
          if (fresh) begin
            state <= nvme_write_pkg::busy_db;
            cq_head <= nvme_write_pkg::slot_t'(cq_head + 1'b1);
            if (cq_head == nvme_write_pkg::slot_t'(nvme_write_pkg::queue_depth - 1)) begin
              old_phase <= ~old_phase;
            end
            sq_head <= nvme_write_pkg::slot_t'(cq_r_data.sq_head);
          end else if (cq_r_valid) begin
            // nothing new yet, poll the same slot again
            state <= nvme_write_pkg::busy_ar;
          end
        end
        nvme_write_pkg::busy_db: begin
          if (db_done) begin
            state <= nvme_write_pkg::idle;
          end
        end
      endcase
    end
  end

  // identifier table, set on issue and cleared on completion
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cid_busy <= '0;
    end else begin
      if (fresh) begin
        cid_busy[nvme_write_pkg::slot_t'(cq_r_data.cid)] <= 1'b0;
      end
      if (issue_valid) begin
        cid_busy[issue_cid] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      db_open <= '0;
    end else if (cq_db_fire && !cq_db_b_valid) begin
      db_open <= db_open + 1'b1;
    end else if (!cq_db_fire && cq_db_b_valid) begin
      db_open <= db_open - 1'b1;
    end
  end

  // the device answers only a poll that is waiting in busy_r
  r_valid_in_busy_r: assert property (
    @(posedge clk) disable iff (!rstn) cq_r_valid |-> cq_r_ready
  );

  db_resp_expected: assert property (
    @(posedge clk) disable iff (!rstn) cq_db_b_valid |-> db_open != '0
  );

endmodule

/* rtl/nvme_write_driver.sv */
`timescale 1ns/100ps

module nvme_write_driver (
  input  logic                      clk,
  input  logic                      rstn,
  // host side
  input  nvme_write_pkg::host_aw_t  host_aw,
  input  logic                      host_aw_valid,
  output logic                      host_aw_ready,
  input  nvme_write_pkg::host_w_t   host_w,
  input  logic                      host_w_valid,
  output logic                      host_w_ready,
  output logic                      host_b_valid,
  input  logic                      host_b_ready,
  // submission queue
  output nvme_write_pkg::sq_addr_t  sq_aw_addr,
  output logic                      sq_aw_valid,
  input  logic                      sq_aw_ready,
  output nvme_write_pkg::sq_entry_t sq_w_data,
  output logic                      sq_w_valid,
  input  logic                      sq_w_ready,
  input  logic                      sq_b_valid,
  output logic                      sq_b_ready,
  // write buffer
  output nvme_write_pkg::buf_aw_t   buf_aw,
  output logic                      buf_aw_valid,
  input  logic                      buf_aw_ready,
  output nvme_write_pkg::host_w_t   buf_w,
  output logic                      buf_w_valid,
  input  logic                      buf_w_ready,
  input  logic                      buf_b_valid,
  output logic                      buf_b_ready,
  // doorbells
  output nvme_write_pkg::db_value_t sq_db_value,
  output logic                      sq_db_valid,
  input  logic                      sq_db_ready,
  input  logic                      sq_db_b_valid,
  output logic                      sq_db_b_ready,
  output nvme_write_pkg::db_value_t cq_db_value,
  output logic                      cq_db_valid,
  input  logic                      cq_db_ready,
  input  logic                      cq_db_b_valid,
  output logic                      cq_db_b_ready,
  // completion queue
  output nvme_write_pkg::cq_addr_t  cq_ar_addr,
  output logic                      cq_ar_valid,
  input  logic                      cq_ar_ready,
  input  nvme_write_pkg::cq_entry_t cq_r_data,
  input  logic                      cq_r_valid,
  output logic                      cq_r_ready
);

  nvme_write_pkg::slot_t                  sq_head;
  nvme_write_pkg::slot_t                  sq_tail;
  logic [nvme_write_pkg::queue_depth-1:0] cid_busy;
  logic                                   issue_valid;

  // write data goes to the buffer slot untouched
  always_comb begin
    buf_w = host_w;
    buf_w_valid = host_w_valid;
    host_w_ready = buf_w_ready;
    // marks the identifier busy as the command leaves
    issue_valid = host_aw_valid & host_aw_ready;
  end

  sq_submit u_submit (.*);

  sq_doorbell u_doorbell (.*);

  cq_poller u_poller (
    .issue_cid(sq_tail),
    .*
  );

endmodule

/* test/nvme_ssd_model.sv */
`timescale 1ns/100ps

module nvme_ssd_model (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      hold,
  input  nvme_write_pkg::sq_addr_t  sq_aw_addr,
  input  logic                      sq_aw_valid,
  output logic                      sq_aw_ready,
  input  nvme_write_pkg::sq_entry_t sq_w_data,
  input  logic                      sq_w_valid,
  output logic                      sq_w_ready,
  output logic                      sq_b_valid,
  input  logic                      sq_b_ready,
  input  nvme_write_pkg::buf_aw_t   buf_aw,
  input  logic                      buf_aw_valid,
  output logic                      buf_aw_ready,
  input  nvme_write_pkg::host_w_t   buf_w,
  input  logic                      buf_w_valid,
  output logic                      buf_w_ready,
  output logic                      buf_b_valid,
  input  logic                      buf_b_ready,
  input  nvme_write_pkg::db_value_t sq_db_value,
  input  logic                      sq_db_valid,
  output logic                      sq_db_ready,
  output logic                      sq_db_b_valid,
  input  logic                      sq_db_b_ready,
  input  nvme_write_pkg::db_value_t cq_db_value,
  input  logic                      cq_db_valid,
  output logic                      cq_db_ready,
  output logic                      cq_db_b_valid,
  input  logic                      cq_db_b_ready,
  input  nvme_write_pkg::cq_addr_t  cq_ar_addr,
  input  logic                      cq_ar_valid,
  output logic                      cq_ar_ready,
  output nvme_write_pkg::cq_entry_t cq_r_data,
  output logic                      cq_r_valid,
  input  logic                      cq_r_ready
);

  nvme_write_pkg::sq_entry_t sq_mem [16];
  nvme_write_pkg::cq_entry_t cq_mem [16];
  nvme_write_pkg::sq_addr_t  aw_q [$];
  nvme_write_pkg::sq_entry_t w_q [$];
  nvme_write_pkg::cq_entry_t r_data_q;
  nvme_write_pkg::slot_t     last_tail;
  int                        head_of [64];
  int                        sq_b_cnt;
  int                        buf_aw_cnt;
  int                        last_cnt;
  int                        buf_b_cnt;
  int                        db_b_cnt;
  int                        cq_db_b_cnt;
  int                        rung;
  int                        posted;
  int                        delay;
  logic                      r_pending;
  logic [31:0]               lfsr;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  initial begin
    lfsr = 32'd76189;
    {sq_aw_ready, sq_w_ready, sq_b_valid, buf_aw_ready, buf_w_ready, buf_b_valid} = '0;
    {sq_db_ready, sq_db_b_valid, cq_db_ready, cq_db_b_valid, cq_ar_ready, cq_r_valid} = '0;
    cq_r_data = '0;
  end

  // bookkeeping of every transfer at the rising edge
  always @(posedge clk) begin
    if (!rstn) begin
      for (int k = 0; k < 16; k++) begin
        cq_mem[k] = '0;
      end
      {sq_b_cnt, buf_aw_cnt, last_cnt, buf_b_cnt, db_b_cnt, cq_db_b_cnt} = '0;
      {rung, posted, delay} = '0;
      last_tail = '0;
      r_pending = 1'b0;
    end else begin
      if (sq_aw_valid && sq_aw_ready) aw_q.push_back(sq_aw_addr);
      if (sq_w_valid && sq_w_ready) w_q.push_back(sq_w_data);
      if (aw_q.size() > 0 && w_q.size() > 0) begin
        sq_mem[aw_q.pop_front() >> 6] = w_q.pop_front();
        sq_b_cnt++;
      end
      if (sq_b_valid && sq_b_ready) sq_b_cnt--;
      if (buf_aw_valid && buf_aw_ready) buf_aw_cnt++;
      if (buf_w_valid && buf_w_ready && buf_w.last) last_cnt++;
      if (buf_aw_cnt > 0 && last_cnt > 0) begin
        buf_aw_cnt--;
        last_cnt--;
        buf_b_cnt++;
      end
      if (buf_b_valid && buf_b_ready) buf_b_cnt--;
      // every entry up to the new tail becomes pending
      if (sq_db_valid && sq_db_ready) begin
        while (last_tail != nvme_write_pkg::slot_t'(sq_db_value)) begin
          head_of[rung] = int'(sq_db_value);
          rung++;
          last_tail = last_tail + 1'b1;
        end
        db_b_cnt++;
      end
      if (sq_db_b_valid && sq_db_b_ready) db_b_cnt--;
      if (cq_db_valid && cq_db_ready) cq_db_b_cnt++;
      if (cq_db_b_valid && cq_db_b_ready) cq_db_b_cnt--;
      if (cq_r_valid && cq_r_ready) r_pending = 1'b0;
      if (cq_ar_valid && cq_ar_ready) begin
        r_pending = 1'b1;
        r_data_q = cq_mem[cq_ar_addr >> 4];
      end
      // post completions in order after a random delay
      if (posted < rung && !hold) begin
        if (delay == 0) begin
          cq_mem[posted % 16] = '{status: '0, phase: ((posted / 16) % 2) == 0,
                                  cid: sq_mem[posted % 16][31:16], sqid: 16'd1,
                                  sq_head: 16'(head_of[posted]), dw: '0};
          posted++;
          delay = int'(rand_bits(3));
        end else begin
          delay--;
        end
      end
    end
  end

  // readies and valids change on the falling edge
  always @(negedge clk) begin
    if (!rstn) begin
      {sq_aw_ready, sq_w_ready, sq_b_valid, buf_aw_ready, buf_w_ready, buf_b_valid} = '0;
      {sq_db_ready, sq_db_b_valid, cq_db_ready, cq_db_b_valid, cq_ar_ready, cq_r_valid} = '0;
    end else begin
      sq_aw_ready = rand_bits(2) != 0;
      sq_w_ready = rand_bits(2) != 0;
      buf_aw_ready = rand_bits(2) != 0;
      buf_w_ready = rand_bits(2) != 0;
      sq_db_ready = rand_bits(1);
      cq_db_ready = rand_bits(1);
      cq_ar_ready = rand_bits(1);
      sq_b_valid = sq_b_cnt > 0 && (sq_b_valid || rand_bits(1));
      buf_b_valid = buf_b_cnt > 0 && (buf_b_valid || rand_bits(1));
      sq_db_b_valid = db_b_cnt > 0 && (sq_db_b_valid || rand_bits(1));
      cq_db_b_valid = cq_db_b_cnt > 0 && (cq_db_b_valid || rand_bits(1));
      cq_r_valid = r_pending && (cq_r_valid || rand_bits(1));
      cq_r_data = r_data_q;
    end
  end

endmodule

/* test/tb_nvme_write_driver.sv */
`timescale 1ns/100ps

module tb_nvme_write_driver;

  localparam int num_writes = 40;
  localparam int wait_limit = 2000;

  logic clk;
  logic rstn;
  logic hold;
  nvme_write_pkg::host_aw_t  host_aw;
  logic host_aw_valid, host_aw_ready;
  nvme_write_pkg::host_w_t   host_w;
  logic host_w_valid, host_w_ready;
  logic host_b_valid, host_b_ready;
  nvme_write_pkg::sq_addr_t  sq_aw_addr;
  logic sq_aw_valid, sq_aw_ready;
  nvme_write_pkg::sq_entry_t sq_w_data;
  logic sq_w_valid, sq_w_ready, sq_b_valid, sq_b_ready;
  nvme_write_pkg::buf_aw_t   buf_aw;
  logic buf_aw_valid, buf_aw_ready;
  nvme_write_pkg::host_w_t   buf_w;
  logic buf_w_valid, buf_w_ready, buf_b_valid, buf_b_ready;
  nvme_write_pkg::db_value_t sq_db_value, cq_db_value;
  logic sq_db_valid, sq_db_ready, sq_db_b_valid, sq_db_b_ready;
  logic cq_db_valid, cq_db_ready, cq_db_b_valid, cq_db_b_ready;
  nvme_write_pkg::cq_addr_t  cq_ar_addr;
  logic cq_ar_valid, cq_ar_ready;
  nvme_write_pkg::cq_entry_t cq_r_data;
  logic cq_r_valid, cq_r_ready;

  int issued, fresh_cnt, b_cnt, sq_db_cnt, cq_db_cnt, cycle;
  logic [31:0] lfsr;

  nvme_write_driver dut (.*);
  nvme_ssd_model ssd (.*);

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic abort_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // running counts of what went through
  always @(posedge clk) begin
    if (!rstn) begin
      {issued, fresh_cnt, b_cnt, sq_db_cnt, cq_db_cnt, cycle} <= '0;
    end else begin
      cycle <= cycle + 1;
      if (host_aw_valid && host_aw_ready) issued <= issued + 1;
      if (cq_r_valid && cq_r_ready && cq_r_data.phase == !fresh_cnt[4]) begin
        fresh_cnt <= fresh_cnt + 1;
      end
      if (host_b_valid && host_b_ready) b_cnt <= b_cnt + 1;
      if (sq_db_valid && sq_db_ready) sq_db_cnt <= sq_db_cnt + 1;
      if (cq_db_valid && cq_db_ready) cq_db_cnt <= cq_db_cnt + 1;
    end
  end

  always @(negedge clk) begin
    host_b_ready <= rstn && (cycle % 3 != 0);
  end

  entry_format: assert property (@(posedge clk) disable iff (!rstn)
    sq_w_valid |-> sq_w_data[7:0] == 8'd1 && sq_w_data[15:8] == '0
      && sq_w_data[31:16] == 16'(issued[3:0])
      && sq_w_data[63:32] == 32'd1 && sq_w_data[191:64] == '0
      && sq_w_data[255:192] == 64'h2040_0000 + 64'(issued[3:0]) * 64'd4096
      && sq_w_data[319:256] == '0
      && sq_w_data[383:320] == 64'(host_aw.addr[47:12]) && sq_w_data[511:384] == '0)
    else report_mismatch("submission entry wrong");

  entry_addr: assert property (@(posedge clk) disable iff (!rstn)
    sq_aw_valid |-> sq_aw_addr == 10'(issued[3:0] * 64))
    else report_mismatch("submission entry address wrong");

  buf_slot: assert property (@(posedge clk) disable iff (!rstn)
    buf_aw_valid |-> buf_aw.addr == 16'(issued[3:0] * 4096) && buf_aw.len == host_aw.len
      && buf_aw.size == host_aw.size && buf_aw.burst == host_aw.burst)
    else report_mismatch("buffer address wrong");

  buf_data: assert property (@(posedge clk) disable iff (!rstn)
    buf_w_valid |-> host_w_valid && buf_w == host_w)
    else report_mismatch("buffer data differs from host data");

  sq_db_order: assert property (@(posedge clk) disable iff (!rstn)
    sq_db_valid |-> sq_b_valid && buf_b_valid && sq_db_value == 16'((sq_db_cnt + 1) % 16))
    else report_mismatch("submission doorbell wrong");

  // write responses retire in the doorbell cycle and in no other
  resp_with_db: assert property (@(posedge clk) disable iff (!rstn)
    sq_b_ready == (sq_db_valid && sq_db_ready)
      && buf_b_ready == (sq_db_valid && sq_db_ready))
    else report_mismatch("write response not taken with the doorbell");

  cq_db_order: assert property (@(posedge clk) disable iff (!rstn)
    cq_db_valid |-> cq_db_value == 16'((cq_db_cnt + 1) % 16))
    else report_mismatch("completion doorbell wrong");

  cq_db_resp_taken: assert property (@(posedge clk) disable iff (!rstn)
    cq_db_b_ready)
    else report_mismatch("completion doorbell response refused");

  r_ready_after_ar: assert property (@(posedge clk) disable iff (!rstn)
    cq_r_ready |-> $past(cq_ar_valid && cq_ar_ready) || $past(cq_r_ready && !cq_r_valid))
    else report_mismatch("completion read ready out of turn");

  b_after_fresh: assert property (@(posedge clk) disable iff (!rstn)
    host_b_valid && host_b_ready |-> b_cnt < fresh_cnt)
    else report_mismatch("host response without completion");

  full_blocks: assert property (@(posedge clk) disable iff (!rstn)
    host_aw_valid && issued - fresh_cnt == 15 |-> !host_aw_ready)
    else report_mismatch("command accepted with full queue");

  poll_addr: assert property (@(posedge clk) disable iff (!rstn)
    cq_ar_valid |-> cq_ar_addr == 8'(fresh_cnt[3:0] * 16))
    else report_mismatch("completion poll address wrong");

  task automatic send_write;
    int t;
    logic [7:0] len;
    logic [15:0] addr_hi;
    logic [31:0] addr_lo;
    len = 8'(rand_bits(2));
    addr_hi = 16'(rand_bits(16));
    addr_lo = rand_bits(32);
    @(negedge clk);
    host_aw = '{addr: {addr_hi, addr_lo}, len: len, size: 3'd4, burst: 2'd1};
    host_aw_valid = 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (t > wait_limit) abort_timeout("host write address");
    end while (!host_aw_ready);
    @(negedge clk);
    host_aw_valid = 1'b0;
    for (int b = 0; b <= int'(len); b++) begin
      host_w = '{data: {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)},
                 strb: '1, last: b == int'(len)};
      host_w_valid = 1'b1;
      t = 0;
      do begin
        @(posedge clk);
        t++;
        if (t > wait_limit) abort_timeout("host write data");
      end while (!host_w_ready);
      @(negedge clk);
      host_w_valid = 1'b0;
    end
  endtask

  // completions held until the queue has been full for a while
  initial begin
    int t;
    hold = 1'b1;
    t = 0;
    while (issued < 15) begin
      @(negedge clk);
      t++;
      if (t > wait_limit) abort_timeout("queue to fill");
    end
    repeat (40) @(negedge clk);
    hold = 1'b0;
  end

  initial begin
    int t;
    lfsr = 32'd76189;
    rstn = 1'b0;
    host_aw = '0;
    host_aw_valid = 1'b0;
    host_w = '0;
    host_w_valid = 1'b0;
    host_b_ready = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    for (int i = 0; i < num_writes; i++) begin
      send_write();
    end
    t = 0;
    while (b_cnt < num_writes && t < wait_limit) begin
      @(negedge clk);
      t++;
    end
    if (b_cnt == num_writes) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("timed out waiting for host write responses");
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

/* verilog.f */
rtl/nvme_write_pkg.sv
rtl/valid_fork.sv
rtl/sq_submit.sv
rtl/sq_doorbell.sv
rtl/cq_poller.sv
rtl/nvme_write_driver.sv
test/nvme_ssd_model.sv
test/tb_nvme_write_driver.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_nvme_write_driver -o tb_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if echo "$out" | grep -q "^Simulation passed$"; then
  exit 0
fi
exit 1
